// ==== design/soc_pkg.sv ====
package soc_pkg;

    // one master request on the 8-bit bus
    typedef struct packed {
        logic [31:0] adr;
        logic [7:0]  dat;
        logic        we;
        logic        stb;
    } bus_req_t;

    // response from a target
    typedef struct packed {
        logic [7:0] dat;
        logic       ack;
    } bus_rsp_t;

    typedef enum logic [2:0] {
        SEL_RAM,
        SEL_TIMER,
        SEL_PRNG,
        SEL_LEDS,
        SEL_NONE
    } periph_sel_e;

    // timer register offsets, ctrl bit0 enable, bit1 irq flag
    typedef enum logic [1:0] {
        REG_RELOAD_LO = 2'd0,
        REG_RELOAD_HI = 2'd1,
        REG_CTRL      = 2'd2,
        REG_COUNT_LO  = 2'd3
    } timer_reg_e;

    // address map
    localparam logic [31:0] ADDR_TIMER_BASE = 32'hFFFF_FD00;
    localparam logic [31:0] ADDR_PRNG_BASE  = 32'hFFFF_FE00;
    localparam logic [31:0] ADDR_LEDS_BASE  = 32'hFFFF_FFF0;
    // reserved pair 0xFFFFFAxx and 0xFFFFFBxx, differ only in bit 8
    localparam logic [31:0] ADDR_RSVD_BASE  = 32'hFFFF_FA00;

endpackage

// ==== design/addr_decoder.sv ====
`timescale 1ns/1ps

module addr_decoder (
    input  soc_pkg::bus_req_t    bus_req_i,
    output soc_pkg::periph_sel_e sel_o,
    output logic                 ram_stb_o,
    output logic                 timer_stb_o,
    output logic                 prng_stb_o,
    output logic                 leds_stb_o,
    output logic                 none_stb_o
);
    import soc_pkg::*;

    // most specific window first, everything unmatched is RAM
    always_comb begin
        if (bus_req_i.adr[31:4] == ADDR_LEDS_BASE[31:4]) begin
            sel_o = SEL_LEDS;
        end else if (bus_req_i.adr[31:8] == ADDR_TIMER_BASE[31:8]) begin
            sel_o = SEL_TIMER;
        end else if (bus_req_i.adr[31:8] == ADDR_PRNG_BASE[31:8]) begin
            sel_o = SEL_PRNG;
        end else if (bus_req_i.adr[31:9] == ADDR_RSVD_BASE[31:9]) begin
            // reserved, answered by the response mux
            sel_o = SEL_NONE;
        end else begin
            sel_o = SEL_RAM;
        end
    end

    // strobe only reaches the chosen target
    assign ram_stb_o   = bus_req_i.stb && (sel_o == SEL_RAM);
    assign timer_stb_o = bus_req_i.stb && (sel_o == SEL_TIMER);
    assign prng_stb_o  = bus_req_i.stb && (sel_o == SEL_PRNG);
    assign leds_stb_o  = bus_req_i.stb && (sel_o == SEL_LEDS);
    assign none_stb_o  = bus_req_i.stb && (sel_o == SEL_NONE);

endmodule

// ==== design/bram_wb8.sv ====
`timescale 1ns/1ps

module bram_wb8 #(
    parameter int RAM_ADDR_BITS = 10
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  soc_pkg::bus_req_t req_i,
    input  logic              stb_i,
    output soc_pkg::bus_rsp_t rsp_o
);

    logic [7:0]               mem [2**RAM_ADDR_BITS];
    logic [RAM_ADDR_BITS-1:0] addr;
    logic [7:0]               dat_q;
    logic                     ack_q;

    // low bits only, upper address bits alias
    assign addr = req_i.adr[RAM_ADDR_BITS-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= stb_i && !ack_q;
        end
    end

    // write lands on the ack edge, read data comes out with ack
    always_ff @(posedge clk) begin
        if (stb_i && !ack_q) begin
            if (req_i.we) begin
                mem[addr] <= req_i.dat;
            end
            dat_q <= mem[addr];
        end
    end

    assign rsp_o = '{dat: dat_q, ack: ack_q};

    assert property (@(posedge clk) disable iff (!rst_n_i) ack_q |=> !ack_q)
        else $error("ram ack held for two cycles");

endmodule

// ==== design/leds_wb8.sv ====
`timescale 1ns/1ps

module leds_wb8 (
    input  logic              clk,
    input  logic              rst_n_i,
    input  soc_pkg::bus_req_t req_i,
    input  logic              stb_i,
    output soc_pkg::bus_rsp_t rsp_o,
    output logic [7:0]        leds_o
);

    logic [7:0] leds_q;
    logic       ack_q;

    // any offset in the window hits the same register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q  <= 1'b0;
            leds_q <= 8'h00;
        end else begin
            ack_q <= stb_i && !ack_q;
            if (stb_i && !ack_q && req_i.we) begin
                leds_q <= req_i.dat;
            end
        end
    end

    assign rsp_o  = '{dat: leds_q, ack: ack_q};
    assign leds_o = leds_q;

endmodule

// ==== design/timer_wb8.sv ====
`timescale 1ns/1ps

module timer_wb8 #(
    parameter int TIMER_PRESCALE = 4
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  soc_pkg::bus_req_t req_i,
    input  logic              stb_i,
    output soc_pkg::bus_rsp_t rsp_o,
    output logic              irq_o
);
    import soc_pkg::*;

    localparam int PW = (TIMER_PRESCALE > 1) ? $clog2(TIMER_PRESCALE) : 1;

    logic [PW-1:0] presc_q;
    logic [15:0]   reload_q;
    logic [15:0]   count_q;
    logic          enable_q;
    logic          irq_q;
    logic          ack_q;
    logic [7:0]    dat_q;
    logic          acc;
    logic          tick;
    timer_reg_e    reg_sel;

    assign reg_sel = timer_reg_e'(req_i.adr[1:0]);
    assign acc     = stb_i && !ack_q;
    assign tick    = enable_q && (presc_q == PW'(TIMER_PRESCALE - 1));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q    <= 1'b0;
            enable_q <= 1'b0;
            irq_q    <= 1'b0;
            presc_q  <= '0;
            count_q  <= '0;
            reload_q <= '0;
        end else begin
            ack_q <= acc;
            // prescaler runs only while enabled
            if (enable_q) begin
                presc_q <= tick ? '0 : presc_q + 1'b1;
            end
            if (tick) begin
                if (count_q == 16'd0) begin
                    count_q <= reload_q;
                    irq_q   <= 1'b1;
                end else begin
                    count_q <= count_q - 16'd1;
                end
            end
            // bus writes override the counting above
            if (acc && req_i.we) begin
                case (reg_sel)
                    REG_RELOAD_LO: reload_q[7:0]  <= req_i.dat;
                    REG_RELOAD_HI: reload_q[15:8] <= req_i.dat;
                    REG_CTRL: begin
                        enable_q <= req_i.dat[0];
                        if (req_i.dat[1]) begin
                            irq_q <= 1'b0;
                        end
                        // enable restarts a full period
                        if (req_i.dat[0]) begin
                            count_q <= reload_q;
                            presc_q <= '0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc) begin
            case (reg_sel)
                REG_RELOAD_LO: dat_q <= reload_q[7:0];
                REG_RELOAD_HI: dat_q <= reload_q[15:8];
                REG_CTRL:      dat_q <= {6'd0, irq_q, enable_q};
                default:       dat_q <= count_q[7:0];
            endcase
        end
    end

    assign rsp_o = '{dat: dat_q, ack: ack_q};
    assign irq_o = irq_q;

    assert property (@(posedge clk) disable iff (!rst_n_i) $rose(irq_o) |-> $past(enable_q))
        else $error("timer irq raised while disabled");

endmodule

// ==== design/prng_wb8.sv ====
`timescale 1ns/1ps

module prng_wb8 (
    input  logic              clk,
    input  logic              rst_n_i,
    input  soc_pkg::bus_req_t req_i,
    input  logic              stb_i,
    output soc_pkg::bus_rsp_t rsp_o
);

    logic [31:0] state_q;
    logic [7:0]  dat_q;
    logic        ack_q;
    logic        acc;
    logic [1:0]  idx;

    // xorshift32 step, 13 / 17 / 5
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    assign acc = stb_i && !ack_q;
    assign idx = req_i.adr[1:0];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q   <= 1'b0;
            state_q <= 32'h0000_0001;
        end else begin
            ack_q <= acc;
            if (acc && req_i.we) begin
                // seed one byte at a time, offset 0 is the lsb
                state_q[8*idx +: 8] <= req_i.dat;
            end else if (acc && idx == 2'd0) begin
                state_q <= xorshift(state_q);
            end
        end
    end

    // returned byte is taken before the advance
    always_ff @(posedge clk) begin
        if (acc) begin
            dat_q <= state_q[8*idx +: 8];
        end
    end

    assign rsp_o = '{dat: dat_q, ack: ack_q};

    // only a seed write may leave the state at zero
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (state_q != 32'd0) && !(acc && req_i.we) |=> state_q != 32'd0)
        else $error("prng state reached zero");

endmodule

// ==== design/resp_mux.sv ====
`timescale 1ns/1ps

module resp_mux (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  soc_pkg::periph_sel_e sel_i,
    input  logic                 none_stb_i,
    input  soc_pkg::bus_rsp_t    ram_rsp_i,
    input  soc_pkg::bus_rsp_t    timer_rsp_i,
    input  soc_pkg::bus_rsp_t    prng_rsp_i,
    input  soc_pkg::bus_rsp_t    leds_rsp_i,
    output soc_pkg::bus_rsp_t    rsp_o
);
    import soc_pkg::*;

    logic none_ack_q;

    // dummy target for the reserved windows so the master never hangs
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            none_ack_q <= 1'b0;
        end else begin
            none_ack_q <= none_stb_i && !none_ack_q;
        end
    end

    always_comb begin
        case (sel_i)
            SEL_RAM:   rsp_o = ram_rsp_i;
            SEL_TIMER: rsp_o = timer_rsp_i;
            SEL_PRNG:  rsp_o = prng_rsp_i;
            SEL_LEDS:  rsp_o = leds_rsp_i;
            default:   rsp_o = '{dat: 8'hFF, ack: none_ack_q};
        endcase
    end

endmodule

// ==== design/soc_bus_top.sv ====
`timescale 1ns/1ps

module soc_bus_top #(
    parameter int RAM_ADDR_BITS  = 10,
    parameter int TIMER_PRESCALE = 4
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  soc_pkg::bus_req_t bus_req_i,
    output soc_pkg::bus_rsp_t bus_rsp_o,
    output logic [7:0]        leds_o,
    output logic              timer_irq_o
);
    import soc_pkg::*;

    periph_sel_e sel;
    logic        ram_stb;
    logic        timer_stb;
    logic        prng_stb;
    logic        leds_stb;
    logic        none_stb;
    bus_rsp_t    ram_rsp;
    bus_rsp_t    timer_rsp;
    bus_rsp_t    prng_rsp;
    bus_rsp_t    leds_rsp;

    addr_decoder i_decoder (
        .bus_req_i   (bus_req_i),
        .sel_o       (sel),
        .ram_stb_o   (ram_stb),
        .timer_stb_o (timer_stb),
        .prng_stb_o  (prng_stb),
        .leds_stb_o  (leds_stb),
        .none_stb_o  (none_stb)
    );

    bram_wb8 #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) i_bram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (bus_req_i),
        .stb_i   (ram_stb),
        .rsp_o   (ram_rsp)
    );

    timer_wb8 #(
        .TIMER_PRESCALE (TIMER_PRESCALE)
    ) i_timer (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (bus_req_i),
        .stb_i   (timer_stb),
        .rsp_o   (timer_rsp),
        .irq_o   (timer_irq_o)
    );

    prng_wb8 i_prng (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (bus_req_i),
        .stb_i   (prng_stb),
        .rsp_o   (prng_rsp)
    );

    leds_wb8 i_leds (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (bus_req_i),
        .stb_i   (leds_stb),
        .rsp_o   (leds_rsp),
        .leds_o  (leds_o)
    );

    resp_mux i_resp_mux (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .sel_i       (sel),
        .none_stb_i  (none_stb),
        .ram_rsp_i   (ram_rsp),
        .timer_rsp_i (timer_rsp),
        .prng_rsp_i  (prng_rsp),
        .leds_rsp_i  (leds_rsp),
        .rsp_o       (bus_rsp_o)
    );

endmodule

// ==== sim/soc_tb.sv ====
`timescale 1ns/1ps

module soc_tb;
    import soc_pkg::*;

    localparam int          RAM_ADDR_BITS  = 10;
    localparam int          TIMER_PRESCALE = 4;
    localparam logic [15:0] TIMER_RELOAD   = 16'd6;
    localparam int          IRQ_WAIT       = (int'(TIMER_RELOAD) + 1) * TIMER_PRESCALE + 4;
    localparam logic [31:0] SEED           = 32'h39de_758d;

    typedef enum {
        OP_WRITE,
        OP_READ,
        OP_LEDS,
        OP_IRQ,
        OP_WAIT_IRQ
    } op_e;

    typedef struct {
        string       name;
        op_e         op;
        logic [31:0] adr;
        logic [7:0]  wdat;
        logic [7:0]  exp;
    } step_t;

    logic       clk;
    logic       rst_n_i;
    bus_req_t   bus_req;
    bus_rsp_t   bus_rsp;
    logic [7:0] leds_o;
    logic       timer_irq_o;

    step_t       steps[$];
    logic [7:0]  ram_model [2**RAM_ADDR_BITS];
    logic [31:0] prng_model = 32'h0000_0001;
    int          err_count = 0;
    int          cycles = 0;
    int          timeout_limit = 0;

    soc_bus_top #(
        .RAM_ADDR_BITS  (RAM_ADDR_BITS),
        .TIMER_PRESCALE (TIMER_PRESCALE)
    ) i_dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .bus_req_i   (bus_req),
        .bus_rsp_o   (bus_rsp),
        .leds_o      (leds_o),
        .timer_irq_o (timer_irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(string name, logic [7:0] expected, logic [7:0] actual);
        if (actual !== expected) begin
            err_count++;
            $display("Error: %s expected 0x%02h actual 0x%02h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // xorshift32 reference, shifts 13 left, 17 right, 5 left
    function automatic logic [31:0] xorshift_next(input logic [31:0] cur);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        a = cur ^ (cur << 13);
        b = a ^ (a >> 17);
        c = b ^ (b << 5);
        return c;
    endfunction

    task automatic add_step(string name, op_e op, logic [31:0] adr, logic [7:0] wdat,
                            logic [7:0] exp);
        step_t s;
        s.name = name;
        s.op   = op;
        s.adr  = adr;
        s.wdat = wdat;
        s.exp  = exp;
        steps.push_back(s);
    endtask

    // one handshake, stb held until ack then dropped a cycle later
    task automatic bus_cycle(logic [31:0] adr, logic we, logic [7:0] wdat,
                             output logic [7:0] rdat);
        int waited;
        @(posedge clk);
        #2;
        bus_req.adr = adr;
        bus_req.dat = wdat;
        bus_req.we  = we;
        bus_req.stb = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!bus_rsp.ack) begin
            waited++;
            if (waited > 4) begin
                abort_run($sformatf("no bus acknowledge within 4 cycles at 0x%08h", adr));
            end
            @(negedge clk);
        end
        rdat = bus_rsp.dat;
        @(posedge clk);
        #2;
        bus_req.stb = 1'b0;
        bus_req.we  = 1'b0;
    endtask

    task automatic timer_irq_wait(int bound);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!timer_irq_o) begin
            waited++;
            if (waited > bound) begin
                abort_run("timer interrupt did not arrive in time");
            end
            @(negedge clk);
        end
    endtask

    task automatic build_steps();
        logic [31:0] ram_adrs [6];
        logic [7:0]  val;
        logic [7:0]  led_val;
        logic [31:0] seed;
        // last two alias 0x005 and 0x3ff in the low address bits
        ram_adrs = '{32'h0000_0000, 32'h0000_0005, 32'h0000_03FF, 32'h0000_1234,
                     32'h0000_0405, 32'hFFFF_F7FF};

        add_step("reset_leds", OP_LEDS, 32'h0, 8'h00, 8'h00);
        add_step("reset_irq", OP_IRQ, 32'h0, 8'h00, 8'h00);
        add_step("reset_prng", OP_READ, ADDR_PRNG_BASE, 8'h00, 8'h01);
        prng_model = xorshift_next(prng_model);

        foreach (ram_adrs[i]) begin
            val = 8'($urandom);
            ram_model[ram_adrs[i][RAM_ADDR_BITS-1:0]] = val;
            add_step($sformatf("ram_write_%0d", i), OP_WRITE, ram_adrs[i], val, 8'h00);
        end
        foreach (ram_adrs[i]) begin
            add_step($sformatf("ram_read_%0d", i), OP_READ, ram_adrs[i], 8'h00,
                     ram_model[ram_adrs[i][RAM_ADDR_BITS-1:0]]);
        end

        led_val = 8'($urandom) | 8'h10;
        add_step("leds_write", OP_WRITE, ADDR_LEDS_BASE, led_val, 8'h00);
        add_step("leds_pins", OP_LEDS, 32'h0, 8'h00, led_val);
        add_step("leds_read", OP_READ, ADDR_LEDS_BASE | 32'h3, 8'h00, led_val);

        // seed bytewise, lsb at offset 0
        seed = $urandom | 32'h1;
        for (int k = 0; k < 4; k++) begin
            add_step($sformatf("prng_seed_%0d", k), OP_WRITE, ADDR_PRNG_BASE | 32'(k),
                     seed[8*k +: 8], 8'h00);
        end
        prng_model = seed;
        for (int k = 0; k < 4; k++) begin
            add_step($sformatf("prng_rd0_%0d", k), OP_READ, ADDR_PRNG_BASE, 8'h00,
                     prng_model[7:0]);
            prng_model = xorshift_next(prng_model);
            add_step($sformatf("prng_rd2_%0d", k), OP_READ, ADDR_PRNG_BASE | 32'h2, 8'h00,
                     prng_model[23:16]);
        end

        add_step("timer_reload_lo", OP_WRITE, ADDR_TIMER_BASE | 32'(REG_RELOAD_LO),
                 TIMER_RELOAD[7:0], 8'h00);
        add_step("timer_reload_hi", OP_WRITE, ADDR_TIMER_BASE | 32'(REG_RELOAD_HI),
                 TIMER_RELOAD[15:8], 8'h00);
        add_step("timer_enable", OP_WRITE, ADDR_TIMER_BASE | 32'(REG_CTRL), 8'h01, 8'h00);
        add_step("timer_wait", OP_WAIT_IRQ, 32'h0, 8'h00, 8'h00);
        add_step("timer_flag_set", OP_READ, ADDR_TIMER_BASE | 32'(REG_CTRL), 8'h00, 8'h03);
        // clear flag and stop the timer in one write
        add_step("timer_clear", OP_WRITE, ADDR_TIMER_BASE | 32'(REG_CTRL), 8'h02, 8'h00);
        add_step("timer_irq_low", OP_IRQ, 32'h0, 8'h00, 8'h00);
        add_step("timer_flag_clr", OP_READ, ADDR_TIMER_BASE | 32'(REG_CTRL), 8'h00, 8'h00);

        add_step("rsvd_read_a", OP_READ, 32'hFFFF_FA10, 8'h00, 8'hFF);
        add_step("rsvd_read_b", OP_READ, 32'hFFFF_FB00, 8'h00, 8'hFF);
        val = 8'($urandom);
        ram_model[10'h210] = val;
        add_step("rsvd_ram_prep", OP_WRITE, 32'h0000_0210, val, 8'h00);
        add_step("rsvd_write_a", OP_WRITE, 32'hFFFF_FA10, ~val, 8'h00);
        add_step("rsvd_ram_keep", OP_READ, 32'h0000_0210, 8'h00, val);
        add_step("rsvd_write_b", OP_WRITE, 32'hFFFF_FB00, ~led_val, 8'h00);
        add_step("rsvd_leds_keep", OP_READ, ADDR_LEDS_BASE, 8'h00, led_val);
        add_step("rsvd_leds_pins", OP_LEDS, 32'h0, 8'h00, led_val);
    endtask

    // run limit, set once the step list is known
    always @(posedge clk) begin
        cycles++;
        if (timeout_limit > 0 && cycles > timeout_limit) begin
            abort_run($sformatf("timeout after %0d cycles", cycles));
        end
    end

    initial begin
        logic [7:0] rdat;
        rst_n_i = 1'b0;
        bus_req = '0;
        void'($urandom(SEED));
        build_steps();
        timeout_limit = steps.size() * 8 + IRQ_WAIT + 200;

        repeat (8) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        foreach (steps[i]) begin
            case (steps[i].op)
                OP_WRITE: begin
                    bus_cycle(steps[i].adr, 1'b1, steps[i].wdat, rdat);
                end
                OP_READ: begin
                    bus_cycle(steps[i].adr, 1'b0, 8'h00, rdat);
                    check_value(steps[i].name, steps[i].exp, rdat);
                end
                OP_LEDS: begin
                    @(negedge clk);
                    check_value(steps[i].name, steps[i].exp, leds_o);
                end
                OP_IRQ: begin
                    @(negedge clk);
                    check_value(steps[i].name, steps[i].exp, {7'd0, timer_irq_o});
                end
                default: begin
                    timer_irq_wait(IRQ_WAIT);
                end
            endcase
        end

        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
design/soc_pkg.sv
design/addr_decoder.sv
design/bram_wb8.sv
design/leds_wb8.sv
design/timer_wb8.sv
design/prng_wb8.sv
design/resp_mux.sv
design/soc_bus_top.sv
sim/soc_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module soc_tb -o soc_sim

./obj_dir/soc_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0
